//--- debug_unit.f
+incdir+.
debug_pkg.sv
frame_serializer.sv
tx_port.sv
instr_loader.sv
debug_ctrl.sv
debug_unit.sv
tb_debug_unit.sv

//--- Makefile
VERILATOR  = verilator
TB_TOP     = tb_debug_unit
RTL_TOP    = debug_unit
FILELIST   = debug_unit.f
OBJ_DIR    = obj_dir
PASS_MSG   = sim passed
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Exit status comes from the search for the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

//--- tb_debug_unit.sv
`timescale 1ns/1ps
`include "debug_defs.svh"

module tb_debug_unit
    import debug_pkg::*;
();

    localparam int DUMP_BITS  = `DBG_NB_ID_EX + `DBG_NB_EX_MEM + `DBG_NB_MEM_WB
                              + `DBG_NB_WB_ID + `DBG_NB_CONTROL;
    localparam int DUMP_BYTES = DUMP_BITS / `DBG_NB_DATA;   // 35 bytes per dump
    localparam int SETTLE     = 6;                          // Quiet window after a phase
    // Four dumps of roughly 310 cycles each, plus load and reset, with ample margin
    localparam int MAX_CYCLES = 4000;

    logic                       clk;
    logic                       i_rst_n;
    logic [`DBG_NB_DATA-1:0]    i_rx;
    logic                       i_rx_done;
    logic                       i_tx_done;
    logic                       i_end;
    id_ex_t                     i_id_ex;
    ex_mem_t                    i_ex_mem;
    mem_wb_t                    i_mem_wb;
    wb_id_t                     i_wb_id;
    control_t                   i_control;
    logic                       o_tx_start;
    logic [`DBG_NB_DATA-1:0]    o_data;
    logic [`DBG_NB_INSTR-1:0]   o_instruction;
    logic [`DBG_NB_INSTR-1:0]   o_instruction_address;
    logic                       o_valid;
    logic                       o_step;
    logic                       o_start;

    integer                     seed = 32'h4a2c;
    int                         errors = 0;
    int                         test_mark = 0;              // Error count at start of test
    int                         tests_run = 0;
    int                         valid_cnt;
    int                         tx_count;
    logic [`DBG_NB_DATA-1:0]    tx_bytes [$];               // Bytes seen by the UART model
    logic [`DBG_NB_INSTR-1:0]   load_words [4];
    logic                       cmd_seen;
    logic                       run_mode;
    logic                       debug_mode;
    logic                       no_step;

    debug_unit DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        for (int c = 0; c < MAX_CYCLES; c++)
            @(posedge clk);
        $display("timeout: tests still running after %0d clock cycles", MAX_CYCLES);
        $display("sim failed");
        $finish;
    end

    // UART transmitter, takes each byte 3 to 6 cycles after it shows up
    initial begin
        int gap;
        i_tx_done = 1'b0;
        tx_count  = 0;
        forever begin
            @(negedge clk);
            if (o_tx_start) begin
                gap = 3 + int'($unsigned($random(seed)) % 4);
                repeat (gap - 1) @(negedge clk);
                tx_bytes.push_back(o_data);
                tx_count  = tx_count + 1;
                i_tx_done = 1'b1;
                @(negedge clk);
                i_tx_done = 1'b0;
            end
        end
    end

    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n)
            valid_cnt <= 0;
        else if (o_valid)
            valid_cnt <= valid_cnt + 1;
    end

    assert property (@(posedge clk) !cmd_seen |-> !(o_valid || o_step || o_start || o_tx_start))
        else flag_error("output active before the first command");
    assert property (@(posedge clk) disable iff (!i_rst_n) o_valid |=> !o_valid)
        else flag_error("o_valid high for more than one cycle");
    assert property (@(posedge clk) disable iff (!i_rst_n) o_valid |-> valid_cnt < 4)
        else flag_error("o_valid pulse after the halt word");
    assert property (@(posedge clk) disable iff (!i_rst_n) o_valid && valid_cnt < 4
                     |-> o_instruction == load_words[valid_cnt]
                         && o_instruction_address == 32'(4 * valid_cnt))
        else flag_error("wrong instruction word or address");
    assert property (@(posedge clk) disable iff (!i_rst_n)
                     i_rx_done && i_rx == `DBG_CMD_RUN && !o_start |=> o_step)
        else flag_error("no o_step after the run command");
    assert property (@(posedge clk) disable iff (!i_rst_n) run_mode && $fell(o_step) |-> $past(i_end))
        else flag_error("o_step fell before i_end");
    assert property (@(posedge clk) disable iff (!i_rst_n) run_mode && i_end |=> !o_step)
        else flag_error("o_step still high after i_end");
    assert property (@(posedge clk) disable iff (!i_rst_n)
                     debug_mode && i_rx_done && i_rx == `DBG_CMD_STEP |=> o_step)
        else flag_error("no o_step after the step command");
    assert property (@(posedge clk) disable iff (!i_rst_n) o_step && !run_mode |=> !o_step)
        else flag_error("step pulse longer than one cycle");
    assert property (@(posedge clk) disable iff (!i_rst_n) no_step || !o_start |-> !o_step)
        else flag_error("o_step without a step or run command");
    assert property (@(posedge clk) disable iff (!i_rst_n)
                     $rose(o_tx_start) |-> tx_count < DUMP_BYTES)
        else flag_error("segment started after a complete dump");

    task automatic flag_error(input string msg);
        errors = errors + 1;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic send_byte(input logic [`DBG_NB_DATA-1:0] b);
        i_rx      = b;
        i_rx_done = 1'b1;
        @(negedge clk);
        i_rx_done = 1'b0;
        repeat (2) @(negedge clk);                          // Idle time between UART frames
    endtask

    // New snapshot values and an empty capture queue before each dump
    task automatic prepare_dump();
        i_id_ex   = id_ex_t'({$random(seed), $random(seed), $random(seed),
                              $random(seed), $random(seed)});
        i_ex_mem  = ex_mem_t'($random(seed));
        i_mem_wb  = mem_wb_t'({$random(seed), $random(seed)});
        i_wb_id   = wb_id_t'({$random(seed), $random(seed)});
        i_control = control_t'($random(seed));
        tx_bytes.delete();
        tx_count = 0;
    endtask

    task automatic collect_dump();
        logic [DUMP_BITS-1:0] frame;
        while (tx_count < DUMP_BYTES)
            @(negedge clk);
        while (o_tx_start)
            @(negedge clk);
        repeat (SETTLE) @(negedge clk);
        frame = {i_id_ex, i_ex_mem, i_mem_wb, i_wb_id, i_control};    // Order on the wire
        assert (tx_count == DUMP_BYTES)
            else flag_error($sformatf("dump has %0d bytes", tx_count));
        for (int i = 0; i < tx_count && i < DUMP_BYTES; i++) begin
            assert (tx_bytes[i] == frame[DUMP_BITS-1-`DBG_NB_DATA*i -: `DBG_NB_DATA])
                else flag_error($sformatf("dump byte %0d is %h", i, tx_bytes[i]));
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_mark);
        test_mark = errors;
        tests_run = tests_run + 1;
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_rx       = '0;
        i_rx_done  = 1'b0;
        i_end      = 1'b0;
        i_id_ex    = '0;
        i_ex_mem   = '0;
        i_mem_wb   = '0;
        i_wb_id    = '0;
        i_control  = '0;
        cmd_seen   = 1'b0;
        run_mode   = 1'b0;
        debug_mode = 1'b0;
        no_step    = 1'b0;
        repeat (8) @(negedge clk);
        i_rst_n = 1'b1;
        repeat (SETTLE) @(negedge clk);
        end_test("reset");

        for (int w = 0; w < 3; w++) begin
            load_words[w] = $random(seed);
            if (load_words[w] == `DBG_HALT_INSTR)
                load_words[w] = '0;
        end
        load_words[3] = `DBG_HALT_INSTR;
        cmd_seen = 1'b1;
        send_byte(`DBG_CMD_LOAD);
        for (int w = 0; w < 4; w++) begin
            for (int b = 3; b >= 0; b--)
                send_byte(load_words[w][`DBG_NB_DATA*b +: `DBG_NB_DATA]);
        end
        for (int k = 0; k < 4; k++)
            send_byte(8'h5a + 8'(k));                       // Not command codes
        repeat (SETTLE) @(negedge clk);
        assert (valid_cnt == 4 && !o_start)
            else flag_error($sformatf("%0d o_valid pulses in the load", valid_cnt));
        end_test("load");

        prepare_dump();
        run_mode = 1'b1;
        send_byte(`DBG_CMD_RUN);
        repeat (20) @(negedge clk);                         // Core runs for a while
        i_end = 1'b1;
        @(negedge clk);
        i_end = 1'b0;
        collect_dump();
        assert (!o_start) else flag_error("o_start still high after the run dump");
        run_mode = 1'b0;
        end_test("run");

        prepare_dump();
        debug_mode = 1'b1;
        send_byte(`DBG_CMD_DEBUG);
        send_byte(`DBG_CMD_STEP);
        collect_dump();
        prepare_dump();
        send_byte(`DBG_CMD_STEP);                           // Still in debug mode
        collect_dump();
        debug_mode = 1'b0;
        end_test("step");

        prepare_dump();
        no_step = 1'b1;
        send_byte(`DBG_CMD_END_DEBUG);
        collect_dump();
        assert (!o_start) else flag_error("o_start still high after end debug");
        prepare_dump();
        send_byte(`DBG_CMD_STEP);                           // IDLE drops it
        repeat (SETTLE) @(negedge clk);
        assert (tx_count == 0) else flag_error("dump after a step outside debug mode");
        end_test("end_debug");

        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- debug_unit.sv
`timescale 1ns/1ps
`include "debug_defs.svh"

module debug_unit
    import debug_pkg::*;
(
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic [`DBG_NB_DATA-1:0]    i_rx,                   // Byte from UART receiver
    input  logic                       i_rx_done,
    input  logic                       i_tx_done,
    input  logic                       i_end,                  // End of program from core
    input  id_ex_t                     i_id_ex,
    input  ex_mem_t                    i_ex_mem,
    input  mem_wb_t                    i_mem_wb,
    input  wb_id_t                     i_wb_id,
    input  control_t                   i_control,
    output logic                       o_tx_start,
    output logic [`DBG_NB_DATA-1:0]    o_data,                 // Byte to UART transmitter
    output logic [`DBG_NB_INSTR-1:0]   o_instruction,
    output logic [`DBG_NB_INSTR-1:0]   o_instruction_address,
    output logic                       o_valid,                // Instruction memory write
    output logic                       o_step,
    output logic                       o_start
);

    logic                       load_en;
    logic                       halt;
    logic [`DBG_NB_SEG-1:0]     seg_go;
    logic [`DBG_NB_SEG-1:0]     seg_done;
    logic [`DBG_NB_SEG-1:0]     seg_active;
    dump_seg_t                  seg_sel;
    logic [`DBG_NB_DATA-1:0]    seg_byte [`DBG_NB_SEG];    // One byte per serializer

    debug_ctrl u_ctrl (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rx       (i_rx),
        .i_rx_done  (i_rx_done),
        .i_end      (i_end),
        .i_halt     (halt),
        .i_seg_done (seg_done),
        .o_load_en  (load_en),
        .o_seg_go   (seg_go),
        .o_seg_sel  (seg_sel),
        .o_step     (o_step),
        .o_start    (o_start)
    );

    instr_loader u_loader (
        .clk                   (clk),
        .i_rst_n               (i_rst_n),
        .i_load_en             (load_en),
        .i_rx                  (i_rx),
        .i_rx_done             (i_rx_done),
        .o_instruction         (o_instruction),
        .o_instruction_address (o_instruction_address),
        .o_valid               (o_valid),
        .o_halt                (halt)
    );

    frame_serializer #(.payload_t(id_ex_t)) u_ser_id_ex (
        .clk (clk), .i_rst_n (i_rst_n), .i_go (seg_go[SEG_ID_EX]), .i_payload (i_id_ex),
        .i_tx_done (i_tx_done), .o_active (seg_active[SEG_ID_EX]),
        .o_byte (seg_byte[SEG_ID_EX]), .o_done (seg_done[SEG_ID_EX])
    );

    frame_serializer #(.payload_t(ex_mem_t)) u_ser_ex_mem (
        .clk (clk), .i_rst_n (i_rst_n), .i_go (seg_go[SEG_EX_MEM]), .i_payload (i_ex_mem),
        .i_tx_done (i_tx_done), .o_active (seg_active[SEG_EX_MEM]),
        .o_byte (seg_byte[SEG_EX_MEM]), .o_done (seg_done[SEG_EX_MEM])
    );

    frame_serializer #(.payload_t(mem_wb_t)) u_ser_mem_wb (
        .clk (clk), .i_rst_n (i_rst_n), .i_go (seg_go[SEG_MEM_WB]), .i_payload (i_mem_wb),
        .i_tx_done (i_tx_done), .o_active (seg_active[SEG_MEM_WB]),
        .o_byte (seg_byte[SEG_MEM_WB]), .o_done (seg_done[SEG_MEM_WB])
    );

    frame_serializer #(.payload_t(wb_id_t)) u_ser_wb_id (
        .clk (clk), .i_rst_n (i_rst_n), .i_go (seg_go[SEG_WB_ID]), .i_payload (i_wb_id),
        .i_tx_done (i_tx_done), .o_active (seg_active[SEG_WB_ID]),
        .o_byte (seg_byte[SEG_WB_ID]), .o_done (seg_done[SEG_WB_ID])
    );

    frame_serializer #(.payload_t(control_t)) u_ser_control (
        .clk (clk), .i_rst_n (i_rst_n), .i_go (seg_go[SEG_CONTROL]), .i_payload (i_control),
        .i_tx_done (i_tx_done), .o_active (seg_active[SEG_CONTROL]),
        .o_byte (seg_byte[SEG_CONTROL]), .o_done (seg_done[SEG_CONTROL])
    );

    tx_port u_tx_port (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_seg_sel  (seg_sel),
        .i_active   (seg_active),
        .i_byte_0   (seg_byte[SEG_ID_EX]),
        .i_byte_1   (seg_byte[SEG_EX_MEM]),
        .i_byte_2   (seg_byte[SEG_MEM_WB]),
        .i_byte_3   (seg_byte[SEG_WB_ID]),
        .i_byte_4   (seg_byte[SEG_CONTROL]),
        .o_tx_start (o_tx_start),
        .o_data     (o_data)
    );

endmodule

//--- debug_ctrl.sv
`timescale 1ns/1ps
`include "debug_defs.svh"

module debug_ctrl
    import debug_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic [`DBG_NB_DATA-1:0]  i_rx,                  // Command byte
    input  logic                     i_rx_done,
    input  logic                     i_end,                 // Core reached end of program
    input  logic                     i_halt,                // Halt word loaded
    input  logic [`DBG_NB_SEG-1:0]   i_seg_done,            // Last byte of a segment sent
    output logic                     o_load_en,
    output logic [`DBG_NB_SEG-1:0]   o_seg_go,              // Start one serializer
    output dump_seg_t                o_seg_sel,
    output logic                     o_step,
    output logic                     o_start
);

    ctrl_state_t              state;
    dump_seg_t                seg;                          // Segment being dumped
    logic                     go_pend;                      // Launch seg on next cycle
    logic                     from_debug;                   // Dump came from a step
    logic [`DBG_NB_SEG-1:0]   seg_go;
    logic                     step;
    logic                     start;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= IDLE;
            seg        <= SEG_ID_EX;
            go_pend    <= 1'b0;
            from_debug <= 1'b0;
            seg_go     <= '0;
            step       <= 1'b0;
            start      <= 1'b0;
        end else begin
            seg_go <= '0;                                   // Single-cycle launch
            case (state)
                IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx)
                            `DBG_CMD_LOAD: begin
                                state <= LOAD;
                                start <= 1'b1;
                            end
                            `DBG_CMD_DEBUG: begin
                                state <= DEBUG;
                                start <= 1'b1;
                            end
                            `DBG_CMD_RUN: begin
                                state <= RUN;
                                start <= 1'b1;
                                step  <= 1'b1;              // Core free-runs
                            end
                            default: state <= IDLE;         // Unknown byte is dropped
                        endcase
                    end
                end

                LOAD: begin
                    if (i_halt) begin
                        state <= IDLE;
                        start <= 1'b0;
                    end
                end

                DEBUG: begin
                    if (i_rx_done) begin
                        case (i_rx)
                            `DBG_CMD_STEP: begin
                                step       <= 1'b1;         // One cycle only, cleared in DUMP
                                from_debug <= 1'b1;
                                state      <= DUMP;
                                seg        <= SEG_ID_EX;
                                go_pend    <= 1'b1;
                            end
                            `DBG_CMD_END_DEBUG: begin
                                from_debug <= 1'b0;
                                state      <= DUMP;
                                seg        <= SEG_ID_EX;
                                go_pend    <= 1'b1;
                            end
                            default: state <= DEBUG;
                        endcase
                    end
                end

                RUN: begin
                    if (i_end) begin
                        step       <= 1'b0;
                        from_debug <= 1'b0;
                        state      <= DUMP;
                        seg        <= SEG_ID_EX;
                        go_pend    <= 1'b1;
                    end
                end

                DUMP: begin
                    step <= 1'b0;
                    // Launch one cycle late so a step has settled in the snapshots
                    if (go_pend) begin
                        seg_go  <= `DBG_NB_SEG'(1) << seg;
                        go_pend <= 1'b0;
                    end else if (i_seg_done[seg]) begin
                        if (seg == SEG_CONTROL) begin
                            state <= from_debug ? DEBUG : IDLE;
                            start <= from_debug;            // Falls only on return to IDLE
                        end else begin
                            seg     <= dump_seg_t'(seg + 3'd1);
                            go_pend <= 1'b1;
                        end
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    assign o_load_en = (state == LOAD);
    assign o_seg_go  = seg_go;
    assign o_seg_sel = seg;
    assign o_step    = step;
    assign o_start   = start;

endmodule

//--- instr_loader.sv
`timescale 1ns/1ps
`include "debug_defs.svh"

module instr_loader (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_load_en,              // Controller is in LOAD
    input  logic [`DBG_NB_DATA-1:0]   i_rx,
    input  logic                      i_rx_done,
    output logic [`DBG_NB_INSTR-1:0]  o_instruction,
    output logic [`DBG_NB_INSTR-1:0]  o_instruction_address,
    output logic                      o_valid,                // Write strobe, one cycle
    output logic                      o_halt                  // Halt word seen
);

    localparam logic [`DBG_NB_INSTR-1:0] ADDR_STEP = `DBG_NB_INSTR'(4);

    logic [`DBG_NB_INSTR-1:0]  instr_reg;
    logic [`DBG_NB_INSTR-1:0]  next_word;
    logic [`DBG_NB_INSTR-1:0]  addr;
    logic [1:0]                byte_cnt;                      // Wraps after the fourth byte
    logic                      valid;
    logic                      halt;

    // MSB first, so each new byte enters at the bottom
    assign next_word = {instr_reg[`DBG_NB_INSTR-`DBG_NB_DATA-1:0], i_rx};

    always_ff @(posedge clk) begin
        if (i_load_en && i_rx_done) begin
            instr_reg <= next_word;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_cnt <= '0;
            addr     <= '0;
            valid    <= 1'b0;
            halt     <= 1'b0;
        end else begin
            valid <= 1'b0;
            halt  <= 1'b0;
            if (!i_load_en) begin
                byte_cnt <= '0;
                addr     <= '0;
            end else begin
                if (valid) begin
                    addr <= addr + ADDR_STEP;                 // After the write completes
                end
                if (i_rx_done) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd3) begin
                        valid <= 1'b1;
                        halt  <= (next_word == `DBG_HALT_INSTR);
                    end
                end
            end
        end
    end

    assign o_instruction         = instr_reg;
    assign o_instruction_address = addr;
    assign o_valid               = valid;
    assign o_halt                = halt;

endmodule

//--- tx_port.sv
`timescale 1ns/1ps
`include "debug_defs.svh"

module tx_port
    import debug_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  dump_seg_t                i_seg_sel,              // Segment now being dumped
    input  logic [`DBG_NB_SEG-1:0]   i_active,
    input  logic [`DBG_NB_DATA-1:0]  i_byte_0,
    input  logic [`DBG_NB_DATA-1:0]  i_byte_1,
    input  logic [`DBG_NB_DATA-1:0]  i_byte_2,
    input  logic [`DBG_NB_DATA-1:0]  i_byte_3,
    input  logic [`DBG_NB_DATA-1:0]  i_byte_4,
    output logic                     o_tx_start,
    output logic [`DBG_NB_DATA-1:0]  o_data
);

    logic [`DBG_NB_DATA-1:0]  sel_byte;

    always_comb begin
        case (i_seg_sel)
            SEG_ID_EX:   sel_byte = i_byte_0;
            SEG_EX_MEM:  sel_byte = i_byte_1;
            SEG_MEM_WB:  sel_byte = i_byte_2;
            SEG_WB_ID:   sel_byte = i_byte_3;
            SEG_CONTROL: sel_byte = i_byte_4;
            default:     sel_byte = i_byte_0;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_tx_start <= 1'b0;
            o_data     <= '0;
        end else begin
            o_tx_start <= i_active[i_seg_sel];               // Level for the whole segment
            o_data     <= sel_byte;
        end
    end

endmodule

//--- frame_serializer.sv
`timescale 1ns/1ps
`include "debug_defs.svh"

module frame_serializer #(
    parameter type payload_t = logic [`DBG_NB_DATA-1:0]
) (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_go,                   // Capture payload and start
    input  payload_t                 i_payload,
    input  logic                     i_tx_done,              // Current byte accepted
    output logic                     o_active,
    output logic [`DBG_NB_DATA-1:0]  o_byte,
    output logic                     o_done                  // After the last byte
);

    localparam int NB_PAYLOAD = $bits(payload_t);
    localparam int NB_BYTES   = NB_PAYLOAD / `DBG_NB_DATA;
    localparam int NB_CNT     = (NB_BYTES > 1) ? $clog2(NB_BYTES) : 1;

    payload_t             shift_reg;
    logic [NB_CNT-1:0]    bytes_left;                          // Bytes after the current one
    logic                 active;
    logic                 done;

    always_ff @(posedge clk) begin
        if (i_go) begin
            shift_reg <= i_payload;
        end else if (active && i_tx_done) begin
            shift_reg <= payload_t'(shift_reg << `DBG_NB_DATA);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active     <= 1'b0;
            done       <= 1'b0;
            bytes_left <= '0;
        end else begin
            done <= 1'b0;
            if (i_go) begin
                active     <= 1'b1;
                bytes_left <= NB_CNT'(NB_BYTES - 1);
            end else if (active && i_tx_done) begin
                if (bytes_left == '0) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end else begin
                    bytes_left <= bytes_left - NB_CNT'(1);
                end
            end
        end
    end

    assign o_byte   = shift_reg[NB_PAYLOAD-1 -: `DBG_NB_DATA];    // Top byte goes first
    assign o_active = active;
    assign o_done   = done;

endmodule

//--- debug_pkg.sv
`include "debug_defs.svh"

package debug_pkg;

    typedef enum logic [2:0] {
        IDLE,                       // Waiting for a command
        LOAD,                       // Receiving instruction bytes
        DEBUG,                      // Waiting for step or end-debug
        RUN,                        // Core runs until i_end
        DUMP                        // Sending the snapshots
    } ctrl_state_t;

    typedef enum logic [2:0] {
        SEG_ID_EX,
        SEG_EX_MEM,
        SEG_MEM_WB,
        SEG_WB_ID,
        SEG_CONTROL                 // Last segment of a dump
    } dump_seg_t;

    typedef logic [`DBG_NB_ID_EX-1:0]   id_ex_t;
    typedef logic [`DBG_NB_EX_MEM-1:0]  ex_mem_t;
    typedef logic [`DBG_NB_MEM_WB-1:0]  mem_wb_t;
    typedef logic [`DBG_NB_WB_ID-1:0]   wb_id_t;
    typedef logic [`DBG_NB_CONTROL-1:0] control_t;

endpackage

//--- debug_defs.svh
`ifndef DEBUG_DEFS_SVH
`define DEBUG_DEFS_SVH

// UART byte and processor word widths
`define DBG_NB_DATA        8
`define DBG_NB_INSTR       32

// Pipeline snapshot widths, all whole bytes
`define DBG_NB_ID_EX       144
`define DBG_NB_EX_MEM      32
`define DBG_NB_MEM_WB      40
`define DBG_NB_WB_ID       40
`define DBG_NB_CONTROL     24

// Command bytes received from the host
`define DBG_CMD_LOAD       8'h01    // Start loading instructions
`define DBG_CMD_DEBUG      8'h02    // Enter debug mode
`define DBG_CMD_RUN        8'h04    // Continuous run
`define DBG_CMD_STEP       8'h08    // Single step, debug mode only
`define DBG_CMD_END_DEBUG  8'h10    // Leave debug mode

// Last word of a program load
`define DBG_HALT_INSTR     32'hffff_ffff

// Number of snapshot segments in one dump
`define DBG_NB_SEG         5

`endif
